/* common/atc_pkg.sv */
/*
 * Shared definitions for the two-runway tower.
 * Message field widths and types, message type codes,
 * reply kinds and the FIFO depth.
 */

`default_nettype none

package atc_pkg;

  ////////////////////////////////////////////////////////////
  // Message layout: plane id, then type, then action
  ////////////////////////////////////////////////////////////

  localparam int PLANE_ID_WIDTH   = 4;
  localparam int MSG_TYPE_WIDTH   = 3;
  localparam int MSG_ACTION_WIDTH = 2;
  localparam int MSG_WIDTH        = PLANE_ID_WIDTH + MSG_TYPE_WIDTH + MSG_ACTION_WIDTH;

  localparam int RUNWAY_COUNT = 2;
  localparam int QUEUE_DEPTH  = 4;

  typedef logic [PLANE_ID_WIDTH-1:0]       plane_id_t;
  typedef logic [MSG_TYPE_WIDTH-1:0]       msg_type_t;
  // Upper bit set for landing, lower bit selects the runway
  typedef logic [MSG_ACTION_WIDTH-1:0]     msg_action_t;
  typedef logic [MSG_WIDTH-1:0]            msg_t;
  typedef logic [$clog2(RUNWAY_COUNT)-1:0] runway_id_t;
  typedef logic [RUNWAY_COUNT-1:0]         runway_mask_t;

  ////////////////////////////////////////////////////////////
  // Message type codes
  ////////////////////////////////////////////////////////////

  localparam msg_type_t TYPE_REQUEST   = 3'd0;
  localparam msg_type_t TYPE_DECLARE   = 3'd1;
  localparam msg_type_t TYPE_EMERGENCY = 3'd2;
  localparam msg_type_t TYPE_CLEAR     = 3'd3;
  localparam msg_type_t TYPE_HOLD      = 3'd4;
  localparam msg_type_t TYPE_SAY_AGAIN = 3'd5;
  localparam msg_type_t TYPE_DIVERT    = 3'd6;

  // What the sequencer asks the reply builder to format
  typedef enum logic [2:0] {
    NONE,
    HOLD,
    SAY_AGAIN,
    DIVERT,
    CLEAR_TAKEOFF,
    CLEAR_LANDING
  } reply_kind_t;

endpackage : atc_pkg

`default_nettype wire

/* src/atc_fifo.sv */
/*
 * Circular-buffer FIFO with an occupancy count
 * and a registered read port.
 */

`timescale 1ns/1ns
`default_nettype none

module atc_fifo #(
  parameter int WIDTH = 9,
  parameter int DEPTH = 4
) (
  input  logic             clock,
  input  logic             reset,
  input  logic [WIDTH-1:0] data_in,
  input  logic             write,
  input  logic             read,
  output logic [WIDTH-1:0] data_out,
  output logic             full,
  output logic             empty
);

  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]       storage [DEPTH];
  logic [PTR_WIDTH-1:0]   put_ptr;
  logic [PTR_WIDTH-1:0]   get_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic                   do_write;
  logic                   do_read;

  assign empty    = (count == '0);
  assign full     = (count == COUNT_WIDTH'(DEPTH));
  // Writes while full and reads while empty are dropped
  assign do_write = write && !full;
  assign do_read  = read && !empty;

  always_ff @(posedge clock) begin
    if (do_write) begin
      storage[put_ptr] <= data_in;
    end
    // Head word shows up on data_out one edge after the read
    if (do_read) begin
      data_out <= storage[get_ptr];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      put_ptr <= '0;
      get_ptr <= '0;
      count   <= '0;
    end else begin
      if (do_write) begin
        put_ptr <= (put_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : put_ptr + 1'b1;
      end
      if (do_read) begin
        get_ptr <= (get_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : get_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule : atc_fifo

`default_nettype wire

/* src/runway_manager.sv */
/*
 * Runway lock registers with the owning plane per runway.
 */

`timescale 1ns/1ns
`default_nettype none

module runway_manager (
  input  logic                 clock,
  input  logic                 reset,
  input  atc_pkg::plane_id_t   plane_id,
  input  atc_pkg::runway_id_t  runway_id,
  input  logic                 lock,
  input  logic                 unlock,
  output atc_pkg::runway_mask_t runway_active
);

  // Plane that currently holds each runway
  atc_pkg::plane_id_t owner [atc_pkg::RUNWAY_COUNT];

  logic owner_match;

  assign owner_match = (owner[runway_id] == plane_id);

  always_ff @(posedge clock) begin
    if (lock) begin
      owner[runway_id] <= plane_id;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      runway_active <= '0;
    end else if (lock) begin
      runway_active[runway_id] <= 1'b1;
    end else if (unlock && owner_match) begin
      // Only the owner may release its runway
      runway_active[runway_id] <= 1'b0;
    end
  end

endmodule : runway_manager

`default_nettype wire

/* tower/request_sequencer.sv */
/*
 * Tower request FSM. Interprets requests, fills and drains
 * the takeoff and landing queues, orders replies and
 * drives the runway lock and unlock strobes.
 */

`timescale 1ns/1ns
`default_nettype none

module request_sequencer (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  request_empty,
  input  atc_pkg::msg_t         request,
  input  atc_pkg::plane_id_t    takeoff_id,
  input  atc_pkg::plane_id_t    landing_id,
  input  logic                  takeoff_full,
  input  logic                  landing_full,
  input  logic                  takeoff_empty,
  input  logic                  landing_empty,
  input  logic                  reply_full,
  input  atc_pkg::runway_mask_t runway_active,
  output logic                  request_read,
  output logic                  queue_takeoff,
  output logic                  queue_landing,
  output logic                  unqueue_takeoff,
  output logic                  unqueue_landing,
  output atc_pkg::reply_kind_t  reply_kind,
  output logic                  queue_reply,
  output logic                  lock,
  output logic                  unlock,
  output atc_pkg::runway_id_t   runway_id,
  output atc_pkg::plane_id_t    runway_plane
);

  typedef enum logic [2:0] {
    QUIET,
    INTERPRET,
    REPLY,
    CHECK_QUEUES,
    CLR_TAKEOFF,
    CLR_LANDING,
    QUEUE_CLR
  } state_t;

  state_t state;
  state_t next_state;

  atc_pkg::plane_id_t   req_plane;
  atc_pkg::msg_type_t   req_type;
  atc_pkg::msg_action_t req_action;
  atc_pkg::runway_id_t  free_runway;
  logic                 takeoff_first;
  logic                 runways_full;

  // Field split of the request word at the FIFO head
  assign req_plane  = request[8:5];
  assign req_type   = request[4:2];
  assign req_action = request[1:0];

  // Lowest-numbered free runway
  assign free_runway  = runway_active[0] ? 1'b1 : 1'b0;
  assign runways_full = &runway_active;

  ////////////////////////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////////////////////////

  always_comb begin
    next_state      = state;
    request_read    = 1'b0;
    queue_takeoff   = 1'b0;
    queue_landing   = 1'b0;
    unqueue_takeoff = 1'b0;
    unqueue_landing = 1'b0;
    reply_kind      = atc_pkg::NONE;
    queue_reply     = 1'b0;
    lock            = 1'b0;
    unlock          = 1'b0;
    runway_id       = '0;
    runway_plane    = req_plane;

    case (state)
      QUIET: begin
        if (!request_empty) begin
          request_read = 1'b1;
          next_state   = INTERPRET;
        end else begin
          next_state = CHECK_QUEUES;
        end
      end

      INTERPRET: begin
        case (req_type)
          atc_pkg::TYPE_REQUEST: begin
            next_state = REPLY;
            if (req_action[1]) begin
              if (landing_full) begin
                reply_kind = atc_pkg::DIVERT;
              end else begin
                queue_landing = 1'b1;
                reply_kind    = atc_pkg::HOLD;
              end
            end else begin
              if (takeoff_full) begin
                reply_kind = atc_pkg::DIVERT;
              end else begin
                queue_takeoff = 1'b1;
                reply_kind    = atc_pkg::HOLD;
              end
            end
          end

          atc_pkg::TYPE_DECLARE: begin
            // No reply, the runway manager checks ownership
            unlock     = 1'b1;
            runway_id  = req_action[0];
            next_state = CHECK_QUEUES;
          end

          // Unknown types, EMERGENCY included
          default: begin
            reply_kind = atc_pkg::SAY_AGAIN;
            next_state = REPLY;
          end
        endcase
      end

      REPLY: begin
        if (!reply_full) begin
          queue_reply = 1'b1;
          next_state  = CHECK_QUEUES;
        end
      end

      CHECK_QUEUES: begin
        next_state = QUIET;
        if (!runways_full) begin
          if (!takeoff_empty && (takeoff_first || landing_empty)) begin
            unqueue_takeoff = 1'b1;
            next_state      = CLR_TAKEOFF;
          end else if (!landing_empty) begin
            unqueue_landing = 1'b1;
            next_state      = CLR_LANDING;
          end
        end
      end

      // Dequeued id is valid here, one cycle after the unqueue
      CLR_TAKEOFF: begin
        lock         = 1'b1;
        runway_id    = free_runway;
        runway_plane = takeoff_id;
        reply_kind   = atc_pkg::CLEAR_TAKEOFF;
        next_state   = QUEUE_CLR;
      end

      CLR_LANDING: begin
        lock         = 1'b1;
        runway_id    = free_runway;
        runway_plane = landing_id;
        reply_kind   = atc_pkg::CLEAR_LANDING;
        next_state   = QUEUE_CLR;
      end

      QUEUE_CLR: begin
        if (!reply_full) begin
          queue_reply = 1'b1;
          next_state  = QUIET;
        end
      end

      default: next_state = QUIET;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= QUIET;
      takeoff_first <= 1'b0;
    end else begin
      state         <= next_state;
      // Free-running tie-break between the two queues
      takeoff_first <= ~takeoff_first;
    end
  end

endmodule : request_sequencer

`default_nettype wire

/* tower/reply_builder.sv */
/*
 * Reply word register. Formats the next outgoing word
 * from the reply kind chosen by the sequencer.
 */

`timescale 1ns/1ns
`default_nettype none

module reply_builder (
  input  logic                 clock,
  input  logic                 reset,
  input  atc_pkg::reply_kind_t reply_kind,
  input  atc_pkg::plane_id_t   request_plane,
  input  atc_pkg::plane_id_t   takeoff_id,
  input  atc_pkg::plane_id_t   landing_id,
  input  atc_pkg::runway_id_t  runway_id,
  output atc_pkg::msg_t        reply_word
);

  // Word is held while the kind is NONE, until the FIFO takes it
  always_ff @(posedge clock) begin
    if (reset) begin
      reply_word <= '0;
    end else begin
      case (reply_kind)
        atc_pkg::HOLD: begin
          reply_word <= {request_plane, atc_pkg::TYPE_HOLD, 2'b00};
        end
        atc_pkg::SAY_AGAIN: begin
          reply_word <= {request_plane, atc_pkg::TYPE_SAY_AGAIN, 2'b00};
        end
        atc_pkg::DIVERT: begin
          reply_word <= {request_plane, atc_pkg::TYPE_DIVERT, 2'b00};
        end
        // Action carries landing flag and runway
        atc_pkg::CLEAR_TAKEOFF: begin
          reply_word <= {takeoff_id, atc_pkg::TYPE_CLEAR, 1'b0, runway_id};
        end
        atc_pkg::CLEAR_LANDING: begin
          reply_word <= {landing_id, atc_pkg::TYPE_CLEAR, 1'b1, runway_id};
        end
        default: begin
          reply_word <= reply_word;
        end
      endcase
    end
  end

endmodule : reply_builder

`default_nettype wire

/* tower/reply_sender.sv */
/*
 * Reply FIFO and the output FSM that hands out one word
 * at a time while the receiver is ready.
 */

`timescale 1ns/1ns
`default_nettype none

module reply_sender (
  input  logic          clock,
  input  logic          reset,
  input  atc_pkg::msg_t reply_word,
  input  logic          queue_reply,
  input  logic          reply_ready,
  output logic          reply_full,
  output atc_pkg::msg_t reply_data,
  output logic          reply_send
);

  typedef enum logic {
    WAIT,
    SEND
  } state_t;

  state_t state;
  logic   reply_empty;
  logic   reply_read;

  atc_fifo #(
    .WIDTH(atc_pkg::MSG_WIDTH),
    .DEPTH(atc_pkg::QUEUE_DEPTH)
  ) reply_fifo (
    .clock   (clock),
    .reset   (reset),
    .data_in (reply_word),
    .write   (queue_reply),
    .read    (reply_read),
    .data_out(reply_data),
    .full    (reply_full),
    .empty   (reply_empty)
  );

  // Read in WAIT, word is on reply_data during SEND
  assign reply_read = (state == WAIT) && !reply_empty && reply_ready;
  assign reply_send = (state == SEND);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= WAIT;
    end else begin
      state <= reply_read ? SEND : WAIT;
    end
  end

endmodule : reply_sender

`default_nettype wire

/* src/atc_top.sv */
/*
 * Tower top level. Request FIFO, takeoff and landing
 * queues, sequencer, reply path and runway locks.
 */

`timescale 1ns/1ns
`default_nettype none

module atc_top (
  input  logic                  clock,
  input  logic                  reset,
  input  atc_pkg::msg_t         request_data,
  input  logic                  request_valid,
  input  logic                  reply_ready,
  output logic                  busy,
  output atc_pkg::msg_t         reply_data,
  output logic                  reply_send,
  output atc_pkg::runway_mask_t runway_active
);

  atc_pkg::msg_t        request_word;
  atc_pkg::plane_id_t   request_plane;
  logic                 request_empty;
  logic                 request_read;

  atc_pkg::plane_id_t   takeoff_id;
  atc_pkg::plane_id_t   landing_id;
  logic                 takeoff_full;
  logic                 landing_full;
  logic                 takeoff_empty;
  logic                 landing_empty;
  logic                 queue_takeoff;
  logic                 queue_landing;
  logic                 unqueue_takeoff;
  logic                 unqueue_landing;

  atc_pkg::reply_kind_t reply_kind;
  atc_pkg::msg_t        reply_word;
  logic                 queue_reply;
  logic                 reply_full;

  logic                 lock;
  logic                 unlock;
  atc_pkg::runway_id_t  runway_id;
  atc_pkg::plane_id_t   runway_plane;

  assign request_plane = request_word[8:5];

  ////////////////////////////////////////////////////////////
  // Request buffering and plane queues
  ////////////////////////////////////////////////////////////

  atc_fifo #(
    .WIDTH(atc_pkg::MSG_WIDTH),
    .DEPTH(atc_pkg::QUEUE_DEPTH)
  ) request_fifo (
    .clock   (clock),
    .reset   (reset),
    .data_in (request_data),
    .write   (request_valid),
    .read    (request_read),
    .data_out(request_word),
    .full    (busy),
    .empty   (request_empty)
  );

  atc_fifo #(
    .WIDTH(atc_pkg::PLANE_ID_WIDTH),
    .DEPTH(atc_pkg::QUEUE_DEPTH)
  ) takeoff_queue (
    .clock   (clock),
    .reset   (reset),
    .data_in (request_plane),
    .write   (queue_takeoff),
    .read    (unqueue_takeoff),
    .data_out(takeoff_id),
    .full    (takeoff_full),
    .empty   (takeoff_empty)
  );

  atc_fifo #(
    .WIDTH(atc_pkg::PLANE_ID_WIDTH),
    .DEPTH(atc_pkg::QUEUE_DEPTH)
  ) landing_queue (
    .clock   (clock),
    .reset   (reset),
    .data_in (request_plane),
    .write   (queue_landing),
    .read    (unqueue_landing),
    .data_out(landing_id),
    .full    (landing_full),
    .empty   (landing_empty)
  );

  ////////////////////////////////////////////////////////////
  // Tower control and reply path
  ////////////////////////////////////////////////////////////

  request_sequencer sequencer (
    .clock          (clock),
    .reset          (reset),
    .request_empty  (request_empty),
    .request        (request_word),
    .takeoff_id     (takeoff_id),
    .landing_id     (landing_id),
    .takeoff_full   (takeoff_full),
    .landing_full   (landing_full),
    .takeoff_empty  (takeoff_empty),
    .landing_empty  (landing_empty),
    .reply_full     (reply_full),
    .runway_active  (runway_active),
    .request_read   (request_read),
    .queue_takeoff  (queue_takeoff),
    .queue_landing  (queue_landing),
    .unqueue_takeoff(unqueue_takeoff),
    .unqueue_landing(unqueue_landing),
    .reply_kind     (reply_kind),
    .queue_reply    (queue_reply),
    .lock           (lock),
    .unlock         (unlock),
    .runway_id      (runway_id),
    .runway_plane   (runway_plane)
  );

  reply_builder builder (
    .clock        (clock),
    .reset        (reset),
    .reply_kind   (reply_kind),
    .request_plane(request_plane),
    .takeoff_id   (takeoff_id),
    .landing_id   (landing_id),
    .runway_id    (runway_id),
    .reply_word   (reply_word)
  );

  reply_sender sender (
    .clock      (clock),
    .reset      (reset),
    .reply_word (reply_word),
    .queue_reply(queue_reply),
    .reply_ready(reply_ready),
    .reply_full (reply_full),
    .reply_data (reply_data),
    .reply_send (reply_send)
  );

  runway_manager runways (
    .clock        (clock),
    .reset        (reset),
    .plane_id     (runway_plane),
    .runway_id    (runway_id),
    .lock         (lock),
    .unlock       (unlock),
    .runway_active(runway_active)
  );

endmodule : atc_top

`default_nettype wire

/* tests/atc_assertions.sv */
/*
 * Concurrent checks on the tower top-level outputs.
 */

`timescale 1ns/1ns
`default_nettype none

module atc_assertions (
  input logic                  clock,
  input logic                  reset,
  input logic                  busy,
  input logic                  reply_send,
  input atc_pkg::msg_t         reply_data,
  input atc_pkg::runway_mask_t runway_active
);

  // Each word needs a FIFO read cycle before its send pulse
  no_back_to_back_send: assert property (
    @(posedge clock) disable iff (reset) reply_send |=> !reply_send
  ) else $error("reply_send was high on two consecutive cycles");

  reset_clears_outputs: assert property (
    @(posedge clock) reset |=> (runway_active == '0) && !busy && !reply_send
  ) else $error("Outputs not in their reset state after reset");

  sent_word_known: assert property (
    @(posedge clock) disable iff (reset) reply_send |-> !$isunknown(reply_data)
  ) else $error("reply_data has unknown bits during reply_send");

endmodule : atc_assertions

`default_nettype wire

/* tests/atc_tb.sv */
/*
 * Testbench for the tower top level. Clock and reset,
 * stimulus file reader, request driver with busy wait,
 * in-order reply monitor, runway checks and watchdog.
 */

`timescale 1ns/1ns
`default_nettype none

module atc_tb;

  localparam int    CLOCK_PERIOD    = 20;
  localparam int    RESET_CYCLES    = 10;
  localparam int    SETTLE_CYCLES   = 30;
  localparam int    CYCLES_PER_LINE = 200;
  localparam int    REPLY_LIMIT     = 400;
  localparam string STIM_PATH       = "tests/atc_stim.txt";

  logic                  clock;
  logic                  reset;
  atc_pkg::msg_t         request_data;
  logic                  request_valid;
  logic                  reply_ready;
  logic                  busy;
  atc_pkg::msg_t         reply_data;
  logic                  reply_send;
  atc_pkg::runway_mask_t runway_active;

  // Parsed stimulus, one entry per command line
  byte           cmd_kind [$];
  logic [31:0]   cmd_value [$];
  // Replies still owed by the DUT, oldest first
  atc_pkg::msg_t expected [$];
  int            line_total;
  logic          stim_loaded;

  atc_top uut (
    .clock        (clock),
    .reset        (reset),
    .request_data (request_data),
    .request_valid(request_valid),
    .reply_ready  (reply_ready),
    .busy         (busy),
    .reply_data   (reply_data),
    .reply_send   (reply_send),
    .runway_active(runway_active)
  );

  bind atc_top atc_assertions checks (
    .clock        (clock),
    .reset        (reset),
    .busy         (busy),
    .reply_send   (reply_send),
    .reply_data   (reply_data),
    .runway_active(runway_active)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Something failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic load_stimulus();
    int          fd;
    int          got;
    string       line;
    byte         kind;
    logic [31:0] value;
    fd = $fopen(STIM_PATH, "r");
    if (fd == 0) begin
      fail_run({"Cannot open the stimulus file ", STIM_PATH});
    end else begin
      while ($fgets(line, fd) > 0) begin
        kind = line.getc(0);
        if (kind == "S" || kind == "E" || kind == "R") begin
          got = $sscanf(line.substr(1, line.len() - 1), "%h", value);
          if (got != 1) begin
            fail_run({"Stimulus line has no value: ", line});
          end else begin
            cmd_kind.push_back(kind);
            cmd_value.push_back(value);
          end
        end else if (kind != "#" && kind != " " && kind != "\n" && kind != "\r") begin
          fail_run({"Unknown command in stimulus line: ", line});
        end
      end
      $fclose(fd);
    end
  endtask

  // Offer one word once the request FIFO has room
  task automatic send_request(input atc_pkg::msg_t word);
    @(posedge clock);
    while (busy) begin
      @(posedge clock);
    end
    request_data  <= word;
    request_valid <= 1'b1;
    @(posedge clock);
    request_valid <= 1'b0;
  endtask

  task automatic wait_for_replies();
    int waited;
    waited = 0;
    while (expected.size() != 0 && waited < REPLY_LIMIT) begin
      @(posedge clock);
      waited++;
    end
    if (expected.size() != 0) begin
      fail_run($sformatf("%0d expected replies did not arrive by %0t",
                         expected.size(), $time));
    end else begin
      repeat (SETTLE_CYCLES) @(posedge clock);
    end
  endtask

  task automatic check_runways(input atc_pkg::runway_mask_t want);
    @(posedge clock);
    assert (runway_active == want) else begin
      fail_run($sformatf("CHECK FAILED at %0t: runway_active expected %b got %b",
                         $time, want, runway_active));
    end
  endtask

  task automatic check_reply(input atc_pkg::msg_t actual);
    atc_pkg::msg_t want;
    if (expected.size() == 0) begin
      fail_run($sformatf("Reply %h was sent at %0t when no reply was expected",
                         actual, $time));
    end else begin
      want = expected.pop_front();
      assert (actual == want) else begin
        fail_run($sformatf("CHECK FAILED at %0t: reply_data expected %h got %h",
                           $time, want, actual));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int seed_result;
    seed_result   = $urandom(32'hc2cc);
    reset         = 1'b1;
    request_data  = '0;
    request_valid = 1'b0;
    reply_ready   = 1'b0;
    stim_loaded   = 1'b0;
    load_stimulus();
    line_total  = cmd_kind.size();
    stim_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;

    foreach (cmd_kind[i]) begin
      case (cmd_kind[i])
        "S": send_request(cmd_value[i][8:0]);
        "E": expected.push_back(cmd_value[i][8:0]);
        default: begin
          wait_for_replies();
          check_runways(cmd_value[i][1:0]);
        end
      endcase
    end

    repeat (SETTLE_CYCLES) @(posedge clock);
    if (expected.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("%0d expected replies were never sent", expected.size());
      $display("Something failed");
      $fatal(1, "Replies missing at the end of the run");
    end
  end

  // Random back-pressure on the reply side
  initial begin
    @(negedge reset);
    forever begin
      @(posedge clock);
      reply_ready <= ($urandom % 3) != 0;
    end
  end

  // Monitor samples before the edge updates the DUT
  initial begin
    forever begin
      @(posedge clock);
      if (reply_send === 1'b1) begin
        check_reply(reply_data);
      end
    end
  end

  initial begin
    wait (stim_loaded);
    #((RESET_CYCLES + line_total * CYCLES_PER_LINE) * CLOCK_PERIOD);
    fail_run($sformatf("Timeout, %0d stimulus lines did not finish in time", line_total));
  end

endmodule : atc_tb

`default_nettype wire

/* tests/atc_stim.txt */
# Columns: command letter, hex value
# S sends a request word, E expects a reply word, R waits for replies and checks runway_active
# Takeoff from plane 3, cleared onto runway 0
E 070
E 06C
S 060
R 1
# Landing from plane 5, cleared onto runway 1
E 0B0
E 0AF
S 0A2
R 3
# Four takeoffs held with both runways busy, plane 12 diverted
E 110
E 130
E 150
E 170
E 198
S 100
S 120
S 140
S 160
S 180
R 3
# Plane 7 does not own runway 0
S 0E4
R 3
# Owners release runways, queued planes take them in order
E 10C
S 064
R 3
E 12D
S 0A5
R 3
E 14C
S 104
R 3
E 16D
S 125
R 3
S 144
R 2
S 165
R 0
# Emergency and type 7 get SAY_AGAIN
E 0D4
S 0C8
E 1B4
S 1BF
R 0

/* src.f */
common/atc_pkg.sv
src/atc_fifo.sv
src/runway_manager.sv
tower/request_sequencer.sv
tower/reply_builder.sv
tower/reply_sender.sv
src/atc_top.sv
tests/atc_assertions.sv
tests/atc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the tower testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
  --top-module atc_tb -f src.f -o atc_sim

output="$(./obj_dir/atc_sim 2>&1)" || true
echo "$output"
grep -qx "Everything OK" <<< "$output"
